// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int wordSize = 16;

    typedef logic [wordSize-1:0] word;
    typedef logic [1:0] regAddr;

    // JAL and JRL write their return address here
    localparam regAddr linkReg = 2'd2;

    // opcode field, instr[15:12]
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opBgz = 4'd2;
    localparam logic [3:0] opBlz = 4'd3;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opOri = 4'd5;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opJal = 4'd10;
    localparam logic [3:0] opRtype = 4'd15;

    // function field of R-type, instr[5:0]
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnTcp = 6'd5;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr,
        aluPassB,
        aluLhi
    } aluOp;

    // write-back source select
    localparam logic [1:0] wbAlu = 2'd0;
    localparam logic [1:0] wbLoad = 2'd1;
    localparam logic [1:0] wbLink = 2'd2;
    localparam logic [1:0] wbLhi = 2'd3;

    // destination register select
    localparam logic [1:0] dstRt = 2'd0;
    localparam logic [1:0] dstRd = 2'd1;
    localparam logic [1:0] dstLink = 2'd2;

    // next PC select
    localparam logic [1:0] pcSeq = 2'd0;
    localparam logic [1:0] pcBranch = 2'd1;
    localparam logic [1:0] pcJump = 2'd2;
    localparam logic [1:0] pcReg = 2'd3;

    typedef enum logic [2:0] {
        stFetch,
        stFetchWait,
        stExecute,
        stMemory,
        stWriteback
    } cpuState;

endpackage

`default_nettype wire

// ==== source/cpuAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuAlu (
    input  wire cpuPkg::word  a,
    input  wire cpuPkg::word  b,
    input  wire cpuPkg::aluOp op,
    output cpuPkg::word       result,
    output logic              overflow
);
    import cpuPkg::*;

    always_comb begin
        result = b;
        overflow = 1'b0;
        case (op)
            aluAdd: begin
                result = a + b;
                // same-sign operands, result sign flipped
                overflow = (a[wordSize-1] == b[wordSize-1])
                    && (result[wordSize-1] != a[wordSize-1]);
            end
            aluSub: begin
                result = a - b;
                overflow = (a[wordSize-1] != b[wordSize-1])
                    && (result[wordSize-1] != a[wordSize-1]);
            end
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluNot: result = ~a;
            aluTcp: result = ~a + 1'b1;
            aluShl: result = {a[wordSize-2:0], 1'b0};
            // arithmetic, sign bit kept
            aluShr: result = {a[wordSize-1], a[wordSize-1:1]};
            aluPassB: result = b;
            // low immediate byte into the upper half
            aluLhi: result = {b[7:0], 8'h00};
            default: result = b;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire cpuPkg::regAddr readAddrA,
    input  wire cpuPkg::regAddr readAddrB,
    input  wire cpuPkg::regAddr writeAddr,
    input  wire cpuPkg::word    writeData,
    input  wire logic           writeEn,
    output cpuPkg::word         readDataA,
    output cpuPkg::word         readDataB
);
    import cpuPkg::*;

    word regs [4];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // asynchronous read, old value during a same-cycle write
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

// ==== source/programCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module programCounter (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        pcLoad,
    input  wire logic [1:0]  pcSel,
    input  wire cpuPkg::word aluResult,
    input  wire cpuPkg::word regValue,
    input  wire logic [11:0] targetField,
    input  wire logic [3:0]  opcodeField,
    input  wire cpuPkg::word cmpA,
    input  wire cpuPkg::word cmpB,
    output cpuPkg::word      pc,
    output logic             takeBranch
);
    import cpuPkg::*;

    word nextPc;
    logic cond;

    always_comb begin
        case (pcSel)
            pcBranch: nextPc = aluResult;
            // page bits of the incremented PC are kept
            pcJump: nextPc = {pc[wordSize-1:12], targetField};
            pcReg: nextPc = regValue;
            default: nextPc = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= nextPc;
        end
    end

    // signed compare, condition picked by low opcode bits
    always_comb begin
        case (opcodeField[1:0])
            2'd0: cond = (cmpA != cmpB);
            2'd1: cond = (cmpA == cmpB);
            2'd2: cond = ($signed(cmpA) > 0);
            default: cond = ($signed(cmpA) < 0);
        endcase
        // branch opcodes sit in 0 to 3
        takeBranch = (opcodeField[3:2] == 2'b00) && cond;
    end

endmodule

`default_nettype wire

// ==== source/memoryPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryPort (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        addrSel,
    input  wire cpuPkg::word pc,
    input  wire cpuPkg::word aluResult,
    input  wire cpuPkg::word storeData,
    input  wire logic        writeM,
    input  wire logic        irLoad,
    input  wire logic        mdrLoad,
    inout  wire cpuPkg::word data,
    output cpuPkg::word      address,
    output cpuPkg::word      instr,
    output cpuPkg::word      loadData
);
    import cpuPkg::*;

    // PC for fetch, effective address for LWD and SWD
    assign address = addrSel ? aluResult : pc;

    // bus is released whenever no store is pending
    assign data = writeM ? storeData : {wordSize{1'bz}};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instr <= '0;
        end else if (irLoad) begin
            instr <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (mdrLoad) begin
            loadData <= data;
        end
    end

endmodule

`default_nettype wire

// ==== source/cpuControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuControl (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire cpuPkg::word instr,
    input  wire logic        takeBranch,
    input  wire logic        inputReady,
    input  wire logic        ackOutput,
    output logic             readM,
    output logic             writeM,
    output logic             irLoad,
    output logic             mdrLoad,
    output logic             regWrite,
    output logic             pcLoad,
    output logic [1:0]       writeSel,
    output logic [1:0]       dstSel,
    output logic [1:0]       pcSel,
    output cpuPkg::aluOp     aluOp,
    output logic             aluSrcA,
    output logic             aluSrcB,
    output logic             addrSel
);
    import cpuPkg::*;

    cpuState state;
    logic [3:0] opcode;
    logic [5:0] funct;
    logic [1:0] jumpSel;
    logic writesReg;
    logic isBranch;
    logic isLoad;
    logic isStore;
    logic fetchDone;

    assign opcode = instr[15:12];
    assign funct = instr[5:0];

    // decoder, depends only on the latched instruction
    always_comb begin
        aluOp = aluPassB;
        aluSrcA = 1'b0;
        aluSrcB = 1'b0;
        writeSel = wbAlu;
        dstSel = dstRt;
        jumpSel = pcSeq;
        writesReg = 1'b0;
        isBranch = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        case (opcode)
            opBne, opBeq, opBgz, opBlz: begin
                // target = incremented PC + offset
                aluOp = aluAdd;
                aluSrcA = 1'b1;
                aluSrcB = 1'b1;
                isBranch = 1'b1;
                jumpSel = pcBranch;
            end
            opAdi: begin
                aluOp = aluAdd;
                aluSrcB = 1'b1;
                writesReg = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                aluSrcB = 1'b1;
                writesReg = 1'b1;
            end
            opLhi: begin
                aluOp = aluLhi;
                aluSrcB = 1'b1;
                writeSel = wbLhi;
                writesReg = 1'b1;
            end
            opLwd: begin
                aluOp = aluAdd;
                aluSrcB = 1'b1;
                writeSel = wbLoad;
                writesReg = 1'b1;
                isLoad = 1'b1;
            end
            opSwd: begin
                aluOp = aluAdd;
                aluSrcB = 1'b1;
                isStore = 1'b1;
            end
            opJmp: jumpSel = pcJump;
            opJal: begin
                jumpSel = pcJump;
                writeSel = wbLink;
                dstSel = dstLink;
                writesReg = 1'b1;
            end
            opRtype: begin
                dstSel = dstRd;
                writesReg = 1'b1;
                case (funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOrr: aluOp = aluOr;
                    fnNot: aluOp = aluNot;
                    fnTcp: aluOp = aluTcp;
                    fnShl: aluOp = aluShl;
                    fnShr: aluOp = aluShr;
                    fnJpr: begin
                        jumpSel = pcReg;
                        writesReg = 1'b0;
                    end
                    fnJrl: begin
                        jumpSel = pcReg;
                        writeSel = wbLink;
                        dstSel = dstLink;
                    end
                    default: writesReg = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    assign fetchDone = (state == stFetch) && readM && inputReady;
    assign irLoad = fetchDone;
    assign mdrLoad = (state == stMemory) && readM && inputReady;
    assign regWrite = (state == stWriteback) && writesReg;
    assign addrSel = (state == stMemory);
    assign pcSel = (state == stFetch) ? pcSeq : jumpSel;

    // linking jumps load the PC at write-back so the link sees the old PC
    always_comb begin
        case (state)
            stFetch: pcLoad = fetchDone;
            stExecute: pcLoad = isBranch ? takeBranch : (jumpSel != pcSeq) && !writesReg;
            stWriteback: pcLoad = (jumpSel != pcSeq);
            default: pcLoad = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stFetch;
            readM <= 1'b0;
            writeM <= 1'b0;
        end else begin
            case (state)
                stFetch: begin
                    if (!readM) begin
                        readM <= 1'b1;
                    end else if (inputReady) begin
                        readM <= 1'b0;
                        state <= stFetchWait;
                    end
                end
                stFetchWait: begin
                    if (!inputReady) begin
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    if (isLoad) begin
                        readM <= 1'b1;
                        state <= stMemory;
                    end else if (isStore) begin
                        writeM <= 1'b1;
                        state <= stMemory;
                    end else if (writesReg) begin
                        state <= stWriteback;
                    end else begin
                        state <= stFetch;
                    end
                end
                stMemory: begin
                    if (writeM) begin
                        if (ackOutput) begin
                            writeM <= 1'b0;
                            state <= stFetch;
                        end
                    end else if (readM) begin
                        if (inputReady) begin
                            readM <= 1'b0;
                        end
                    end else if (!inputReady) begin
                        state <= stWriteback;
                    end
                end
                stWriteback: state <= stFetch;
                default: state <= stFetch;
            endcase
        end
    end

    noBusOverlap: assert property (@(posedge clk) disable iff (!rstN) !(readM && writeM))
        else $error("readM and writeM high together");

    writeOnlyInWriteback: assert property (@(posedge clk) disable iff (!rstN)
        regWrite |-> state == stWriteback)
        else $error("register write outside write-back");

endmodule

`default_nettype wire

// ==== source/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire logic        clk,
    input  wire logic        rstN,
    output logic             readM,
    output logic             writeM,
    output cpuPkg::word      address,
    inout  wire cpuPkg::word data,
    input  wire logic        inputReady,
    input  wire logic        ackOutput
);
    import cpuPkg::*;

    word instr;
    word pc;
    word readDataA;
    word readDataB;
    word aluA;
    word aluB;
    word aluResult;
    word loadData;
    word writeData;
    word immExt;
    regAddr rsIdx;
    regAddr rtIdx;
    regAddr rdIdx;
    regAddr writeAddr;
    cpuPkg::aluOp aluOpSel;
    logic takeBranch;
    logic irLoad;
    logic mdrLoad;
    logic regWrite;
    logic pcLoad;
    logic aluSrcA;
    logic aluSrcB;
    logic addrSel;
    logic [1:0] writeSel;
    logic [1:0] dstSel;
    logic [1:0] pcSel;

    assign rsIdx = instr[11:10];
    assign rtIdx = instr[9:8];
    assign rdIdx = instr[7:6];
    assign immExt = {{8{instr[7]}}, instr[7:0]};

    assign aluA = aluSrcA ? pc : readDataA;
    assign aluB = aluSrcB ? immExt : readDataB;

    always_comb begin
        case (dstSel)
            dstRd: writeAddr = rdIdx;
            dstLink: writeAddr = linkReg;
            default: writeAddr = rtIdx;
        endcase
    end

    // LHI result also comes out of the ALU
    always_comb begin
        case (writeSel)
            wbLoad: writeData = loadData;
            wbLink: writeData = pc;
            default: writeData = aluResult;
        endcase
    end

    cpuControl controlUnit (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .takeBranch (takeBranch),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .readM      (readM),
        .writeM     (writeM),
        .irLoad     (irLoad),
        .mdrLoad    (mdrLoad),
        .regWrite   (regWrite),
        .pcLoad     (pcLoad),
        .writeSel   (writeSel),
        .dstSel     (dstSel),
        .pcSel      (pcSel),
        .aluOp      (aluOpSel),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .addrSel    (addrSel)
    );

    registerFile regFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (rsIdx),
        .readAddrB (rtIdx),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .writeEn   (regWrite),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    // overflow is reported but has no consumer yet
    cpuAlu alu (
        .a        (aluA),
        .b        (aluB),
        .op       (aluOpSel),
        .result   (aluResult),
        .overflow ()
    );

    programCounter pcUnit (
        .clk         (clk),
        .rstN        (rstN),
        .pcLoad      (pcLoad),
        .pcSel       (pcSel),
        .aluResult   (aluResult),
        .regValue    (readDataA),
        .targetField (instr[11:0]),
        .opcodeField (instr[15:12]),
        .cmpA        (readDataA),
        .cmpB        (readDataB),
        .pc          (pc),
        .takeBranch  (takeBranch)
    );

    memoryPort memPort (
        .clk       (clk),
        .rstN      (rstN),
        .addrSel   (addrSel),
        .pc        (pc),
        .aluResult (aluResult),
        .storeData (readDataB),
        .writeM    (writeM),
        .irLoad    (irLoad),
        .mdrLoad   (mdrLoad),
        .data      (data),
        .address   (address),
        .instr     (instr),
        .loadData  (loadData)
    );

endmodule

`default_nettype wire

// ==== sim/memoryModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryModel (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        readM,
    input  wire logic        writeM,
    input  wire cpuPkg::word address,
    inout  wire cpuPkg::word data,
    output logic             inputReady,
    output logic             ackOutput
);
    import cpuPkg::*;

    word words [256];
    word logAddr [64];
    word logData [64];
    int storeCount;
    int waitLeft;
    logic pending;
    integer seed = 32'h979a_2c55;

    initial begin
        inputReady = 1'b0;
        ackOutput = 1'b0;
        pending = 1'b0;
        storeCount = 0;
        waitLeft = 0;
    end

    // read word sits on the bus for the whole read strobe
    assign data = (readM && !writeM) ? words[address[7:0]] : {wordSize{1'bz}};

    task automatic loadWord(input logic [7:0] addr, input word value);
        words[addr] = value;
    endtask

    // handshake outputs change on the falling edge only
    always @(negedge clk) begin
        if (!rstN) begin
            storeCount <= 0;
        end
        if (!rstN || (!readM && !writeM)) begin
            inputReady <= 1'b0;
            ackOutput <= 1'b0;
            pending <= 1'b0;
        end else if (!pending && !inputReady && !ackOutput) begin
            // answer after one to three more cycles
            pending <= 1'b1;
            waitLeft <= 1 + ($unsigned($random(seed)) % 3);
        end else if (pending) begin
            if (waitLeft > 1) begin
                waitLeft <= waitLeft - 1;
            end else begin
                pending <= 1'b0;
                if (writeM) begin
                    ackOutput <= 1'b1;
                    words[address[7:0]] = data;
                    logAddr[storeCount] <= address;
                    logData[storeCount] <= data;
                    storeCount <= storeCount + 1;
                end else begin
                    inputReady <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/cpuCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;
    import cpuPkg::*;

    // five programs, about 80 instructions of at most 12 cycles each, wide margin
    localparam int maxCycles = 4000;

    logic clk = 1'b0;
    logic rstN = 1'b0;
    logic readM;
    logic writeM;
    logic inputReady;
    logic ackOutput;
    word address;
    wire word data;

    word expAddr[$];
    word expData[$];
    word loadAddr;
    word haltAddr;
    int cycleCount = 0;
    logic writeHeld = 1'b0;
    word heldAddr;
    word heldData;

    cpuCore UUT (
        .clk        (clk),
        .rstN       (rstN),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .data       (data),
        .inputReady (inputReady),
        .ackOutput  (ackOutput)
    );

    memoryModel memory (
        .clk        (clk),
        .rstN       (rstN),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .data       (data),
        .inputReady (inputReady),
        .ackOutput  (ackOutput)
    );

    always #50 clk = ~clk;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareWord(input string name, input word got, input word expected);
        if (got !== expected) begin
            stopWithFailure($sformatf("error at %0d ns: %s is %h, expected %h",
                $time, name, got, expected));
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stopWithFailure($sformatf("error at %0d ns: %s is %b, expected %b",
                $time, name, got, expected));
        end
    endtask

    task automatic compareCount(input string name, input int got, input int expected);
        if (got != expected) begin
            stopWithFailure($sformatf("error at %0d ns: %s is %0d, expected %0d",
                $time, name, got, expected));
        end
    endtask

    function automatic word signExtend(input logic [7:0] imm);
        return {{8{imm[7]}}, imm};
    endfunction

    function automatic word encodeI(input logic [3:0] op, input regAddr rs, input regAddr rt,
            input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word encodeR(input regAddr rs, input regAddr rt, input regAddr rd,
            input logic [5:0] fn);
        return {opRtype, rs, rt, rd, fn};
    endfunction

    function automatic word encodeJ(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic emit(input word instr);
        memory.loadWord(loadAddr[7:0], instr);
        loadAddr = loadAddr + 16'd1;
    endtask

    // program ends in a jump to itself
    task automatic emitHalt();
        haltAddr = loadAddr;
        emit(encodeJ(opJmp, loadAddr[11:0]));
    endtask

    task automatic expectStore(input word addr, input word value);
        expAddr.push_back(addr);
        expData.push_back(value);
    endtask

    task automatic beginProgram();
        rstN = 1'b0;
        expAddr.delete();
        expData.delete();
        loadAddr = '0;
        // undefined opcode 0xE in every unused word
        for (int i = 0; i < 256; i++) begin
            memory.loadWord(i[7:0], {8'hE5, i[7:0] ^ 8'h5A});
        end
    endtask

    task automatic runProgram();
        repeat (16) @(negedge clk);
        compareBit("readM", readM, 1'b0);
        compareBit("writeM", writeM, 1'b0);
        rstN = 1'b1;
        while (memory.storeCount < expAddr.size()) @(negedge clk);
        while (!(readM && address == haltAddr)) @(negedge clk);
        compareCount("store count", memory.storeCount, expAddr.size());
        for (int i = 0; i < expAddr.size(); i++) begin
            compareWord($sformatf("store %0d address", i), memory.logAddr[i], expAddr[i]);
            compareWord($sformatf("store %0d data", i), memory.logData[i], expData[i]);
        end
    endtask

    task automatic testImmediateArith();
        word r1;
        word r2;
        word r3;
        beginProgram();
        r1 = 16'h0000 + signExtend(8'h35);
        r2 = {8'h12, 8'h00} | signExtend(8'h34);
        r3 = signExtend(8'hF0);
        emit(encodeI(opAdi, 2'd0, 2'd1, 8'h35));
        emit(encodeI(opSwd, 2'd0, 2'd1, 8'h40));
        emit(encodeI(opLhi, 2'd0, 2'd2, 8'h12));
        emit(encodeI(opOri, 2'd2, 2'd2, 8'h34));
        emit(encodeI(opSwd, 2'd0, 2'd2, 8'h41));
        emit(encodeI(opAdi, 2'd0, 2'd3, 8'hF0));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h42));
        emit(encodeR(2'd2, 2'd3, 2'd1, fnAdd));
        emit(encodeI(opSwd, 2'd0, 2'd1, 8'h43));
        emit(encodeR(2'd3, 2'd2, 2'd1, fnSub));
        emit(encodeI(opSwd, 2'd0, 2'd1, 8'h44));
        emit(encodeR(2'd2, 2'd0, 2'd1, fnTcp));
        emit(encodeI(opSwd, 2'd0, 2'd1, 8'h45));
        emit(encodeI(opOri, 2'd0, 2'd3, 8'h80));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h46));
        emitHalt();
        expectStore(16'h0040, r1);
        expectStore(16'h0041, r2);
        expectStore(16'h0042, r3);
        expectStore(16'h0043, r2 + r3);
        expectStore(16'h0044, r3 - r2);
        expectStore(16'h0045, 16'h0000 - r2);
        expectStore(16'h0046, 16'h0000 | signExtend(8'h80));
        runProgram();
    endtask

    task automatic testLogicShift();
        word r1;
        word r2;
        beginProgram();
        r1 = {8'hA5, 8'h00} | signExtend(8'h3C);
        r2 = {8'h0F, 8'h00} | signExtend(8'h0F);
        emit(encodeI(opLhi, 2'd0, 2'd1, 8'hA5));
        emit(encodeI(opOri, 2'd1, 2'd1, 8'h3C));
        emit(encodeI(opLhi, 2'd0, 2'd2, 8'h0F));
        emit(encodeI(opOri, 2'd2, 2'd2, 8'h0F));
        emit(encodeR(2'd1, 2'd2, 2'd3, fnAnd));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h40));
        emit(encodeR(2'd1, 2'd2, 2'd3, fnOrr));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h41));
        emit(encodeR(2'd1, 2'd0, 2'd3, fnNot));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h42));
        emit(encodeR(2'd1, 2'd0, 2'd3, fnShl));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h43));
        emit(encodeR(2'd1, 2'd0, 2'd3, fnShr));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h44));
        emit(encodeR(2'd2, 2'd0, 2'd3, fnShr));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h45));
        emitHalt();
        expectStore(16'h0040, r1 & r2);
        expectStore(16'h0041, r1 | r2);
        expectStore(16'h0042, ~r1);
        expectStore(16'h0043, r1 << 1);
        // sign bit copied in from the left
        expectStore(16'h0044, $signed(r1) >>> 1);
        expectStore(16'h0045, $signed(r2) >>> 1);
        runProgram();
    endtask

    task automatic testLoads();
        word base;
        word negAddr;
        beginProgram();
        base = signExtend(8'h50);
        negAddr = base + signExtend(8'hFE);
        memory.loadWord(base[7:0], 16'hBEEF);
        memory.loadWord(base[7:0] + 8'd1, 16'h1357);
        memory.loadWord(negAddr[7:0], 16'h8001);
        emit(encodeI(opAdi, 2'd0, 2'd1, 8'h50));
        emit(encodeI(opLwd, 2'd1, 2'd2, 8'h00));
        emit(encodeI(opSwd, 2'd0, 2'd2, 8'h60));
        emit(encodeI(opLwd, 2'd1, 2'd3, 8'h01));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h61));
        // negative offset reaches below the base
        emit(encodeI(opLwd, 2'd1, 2'd3, 8'hFE));
        emit(encodeI(opSwd, 2'd0, 2'd3, 8'h62));
        emitHalt();
        expectStore(16'h0060, 16'hBEEF);
        expectStore(16'h0061, 16'h1357);
        expectStore(16'h0062, 16'h8001);
        runProgram();
    endtask

    // branch skips two words, fall-through stores slot, taken path slot+1
    task automatic branchCase(input logic [3:0] op, input regAddr rs, input regAddr rt,
            input logic taken, input logic [7:0] slot, input word value);
        word next;
        next = loadAddr + 16'd4;
        emit(encodeI(op, rs, rt, 8'h02));
        emit(encodeI(opSwd, 2'd0, 2'd1, slot));
        emit(encodeJ(opJmp, next[11:0]));
        emit(encodeI(opSwd, 2'd0, 2'd1, slot + 8'd1));
        expectStore({8'h00, taken ? slot + 8'd1 : slot}, value);
    endtask

    task automatic testBranches();
        word a;
        word b;
        word c;
        word start;
        beginProgram();
        a = signExtend(8'h05);
        b = signExtend(8'h05);
        c = signExtend(8'hFD);
        emit(encodeI(opAdi, 2'd0, 2'd1, 8'h05));
        emit(encodeI(opAdi, 2'd0, 2'd2, 8'h05));
        emit(encodeI(opAdi, 2'd0, 2'd3, 8'hFD));
        branchCase(opBne, 2'd1, 2'd2, a != b, 8'h40, a);
        branchCase(opBeq, 2'd1, 2'd2, a == b, 8'h42, a);
        branchCase(opBgz, 2'd3, 2'd0, $signed(c) > 0, 8'h44, a);
        branchCase(opBlz, 2'd3, 2'd0, $signed(c) < 0, 8'h46, a);
        branchCase(opBne, 2'd1, 2'd3, a != c, 8'h48, a);
        branchCase(opBlz, 2'd1, 2'd0, $signed(a) < 0, 8'h4A, a);
        branchCase(opBgz, 2'd1, 2'd0, $signed(a) > 0, 8'h4C, a);
        // backward branch from start+3 to start+1
        start = loadAddr;
        emit(encodeJ(opJmp, start[11:0] + 12'd3));
        emit(encodeI(opSwd, 2'd0, 2'd1, 8'h50));
        emit(encodeJ(opJmp, start[11:0] + 12'd5));
        emit(encodeI(opBgz, 2'd1, 2'd0, 8'hFD));
        emit(encodeI(opSwd, 2'd0, 2'd1, 8'h51));
        emitHalt();
        expectStore(($signed(a) > 0) ? 16'h0050 : 16'h0051, a);
        runProgram();
    endtask

    task automatic testJumps();
        beginProgram();
        emit(encodeJ(opJmp, 12'd3));
        emit(encodeI(opSwd, 2'd0, 2'd0, 8'h4F));
        emit(encodeJ(opJmp, 12'd2));
        // JAL at 3, subroutine at 9 returns through r2
        emit(encodeJ(opJal, 12'd9));
        emit(encodeI(opSwd, 2'd0, 2'd2, 8'h41));
        emit(encodeI(opAdi, 2'd0, 2'd1, 8'd11));
        // JRL at 6 to the routine at 11
        emit(encodeR(2'd1, 2'd0, 2'd0, fnJrl));
        emit(encodeI(opSwd, 2'd0, 2'd2, 8'h43));
        emitHalt();
        emit(encodeI(opSwd, 2'd0, 2'd2, 8'h40));
        emit(encodeR(2'd2, 2'd0, 2'd0, fnJpr));
        emit(encodeI(opSwd, 2'd0, 2'd2, 8'h42));
        emit(encodeR(2'd2, 2'd0, 2'd0, fnJpr));
        expectStore(16'h0040, 16'd3 + 16'd1);
        expectStore(16'h0041, 16'd3 + 16'd1);
        expectStore(16'h0042, 16'd6 + 16'd1);
        expectStore(16'h0043, 16'd6 + 16'd1);
        runProgram();
    endtask

    // bus watch, address and data must hold while a store waits
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            if (readM && writeM) begin
                stopWithFailure("bus rule broken: readM and writeM are high together");
            end
            if (writeM && writeHeld) begin
                compareWord("address", address, heldAddr);
                compareWord("data", data, heldData);
            end
        end
        writeHeld <= (rstN === 1'b1) && writeM;
        heldAddr <= address;
        heldData <= data;
    end

    always @(negedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            stopWithFailure($sformatf("the run timed out after %0d cycles", maxCycles));
        end
    end

    initial begin
        testImmediateArith();
        testLogicShift();
        testLoads();
        testBranches();
        testJumps();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpuCore.f ====
source/cpuPkg.sv
source/cpuAlu.sv
source/registerFile.sv
source/programCounter.sv
source/memoryPort.sv
source/cpuControl.sv
source/cpuCore.sv
sim/memoryModel.sv
sim/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpuCore

sources:
  - source/cpuPkg.sv
  - source/cpuAlu.sv
  - source/registerFile.sv
  - source/programCounter.sv
  - source/memoryPort.sv
  - source/cpuControl.sv
  - source/cpuCore.sv
  - target: simulation
    files:
      - sim/memoryModel.sv
      - sim/cpuCoreTb.sv
